// File: design/cdic_pkg.sv
`default_nettype none

package cdic_pkg;

    typedef logic [15:0] cdic_word_t;
    typedef logic [12:0] ram_addr_t;

    // Register map in word addresses
    localparam ram_addr_t reg_cmd_addr     = 13'h1E00;
    localparam ram_addr_t reg_time_hi_addr = 13'h1E01;
    localparam ram_addr_t reg_time_lo_addr = 13'h1E02;
    localparam ram_addr_t reg_file_addr    = 13'h1E03;
    localparam ram_addr_t reg_chan_hi_addr = 13'h1E04;
    localparam ram_addr_t reg_chan_lo_addr = 13'h1E05;
    localparam ram_addr_t reg_xbuf_addr    = 13'h1FFB;
    localparam ram_addr_t reg_dbuf_addr    = 13'h1FFF;

    // Everything below this is sector memory
    localparam ram_addr_t ram_limit_addr   = 13'h1E00;

    localparam cdic_word_t cmd_stop       = 16'h0023;
    localparam cdic_word_t cmd_read_mode1 = 16'h0029;
    localparam cdic_word_t cmd_read_mode2 = 16'h002A;
    localparam cdic_word_t cmd_seek       = 16'h002C;

    // Word positions inside a sector, counted from the sync pattern
    localparam int hdr_mode_index     = 7;
    localparam int hdr_file_index     = 8;
    localparam int hdr_submode_index  = 9;
    localparam int filter_index       = 10;
    localparam int first_stored_index = 8;

    localparam ram_addr_t buffer_base_a = 13'h0500;
    localparam ram_addr_t buffer_base_b = 13'h0000;
    // Room for the time code at the start of a buffer
    localparam ram_addr_t stored_offset = 13'd2;

    localparam int spin_down_ticks = 3;

    typedef struct packed {
        logic [3:0] min_tens;
        logic [3:0] min_units;
        logic [3:0] sec_tens;
        logic [3:0] sec_units;
        logic [3:0] frame_tens;
        logic [3:0] frame_units;
        logic [7:0] reserved;
    } msf_digits_t;

    // Written by the CPU as two words, decoded as BCD digits
    typedef union packed {
        cdic_word_t [1:0] half;
        msf_digits_t      digits;
    } time_reg_u;

    // MODE2 sub-header submode byte, MSB first
    typedef struct packed {
        logic eof;
        logic rt;
        logic form;
        logic trig;
        logic data;
        logic audio;
        logic video;
        logic eor;
    } submode_t;

endpackage

`default_nettype wire

// File: design/cdic_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// CPU side port of the sector memory
interface ram_port_if import cdic_pkg::*; ();

    ram_addr_t  addr;
    cdic_word_t wdata;
    logic       we;
    cdic_word_t rdata;

    modport master (output addr, output wdata, output we, input rdata);
    modport slave  (input addr, input wdata, input we, output rdata);

endinterface

// Link between the register file and the sector receiver
interface sector_ctrl_if ();

    logic        reading_active;
    logic        read_mode2;
    logic [7:0]  file_id;
    logic [31:0] channel_mask;
    logic        restart;
    logic        sector_stored;
    logic        stored_in_a;

    modport control (
        output reading_active, read_mode2, file_id, channel_mask, restart,
        input  sector_stored, stored_in_a
    );

    modport receiver (
        input  reading_active, read_mode2, file_id, channel_mask, restart,
        output sector_stored, stored_in_a
    );

endinterface

`default_nettype wire

// File: design/msf_to_lba.sv
`timescale 1ns/1ps
`default_nettype none

module msf_to_lba import cdic_pkg::*; (
    input  wire time_reg_u   msf,
    output logic [31:0]      lba
);

    always_comb begin
        logic [31:0] minutes;
        logic [31:0] seconds;
        logic [31:0] frames;

        minutes = 32'(msf.digits.min_tens) * 32'd10 + 32'(msf.digits.min_units);
        seconds = 32'(msf.digits.sec_tens) * 32'd10 + 32'(msf.digits.sec_units);
        frames  = 32'(msf.digits.frame_tens) * 32'd10 + 32'(msf.digits.frame_units);

        // A valid frame count ends at BCD 74, so the top bit never shows up
        // in normal use. Seek relies on it to round down to a full second
        if (msf.digits.frame_tens[3]) begin
            frames = 32'd0;
        end

        lba = (minutes * 32'd60 + seconds) * 32'd75 + frames;
    end

endmodule

`default_nettype wire

// File: design/sector_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sector_ram import cdic_pkg::*; (
    input wire              clk,
    input wire ram_addr_t   port_b_addr,
    input wire cdic_word_t  port_b_data,
    input wire              port_b_we,
    ram_port_if.slave       cpu
);

    localparam int ram_depth = 2 ** $bits(ram_addr_t);

    cdic_word_t mem [0:ram_depth-1];

    // Port A, CPU read and write, read data one cycle later
    always @(posedge clk) begin
        if (cpu.we) begin
            mem[cpu.addr] <= cpu.wdata;
        end
        cpu.rdata <= mem[cpu.addr];
    end

    // Port B, incoming CD words only
    always @(posedge clk) begin
        if (port_b_we) begin
            mem[port_b_addr] <= port_b_data;
        end
    end

endmodule

`default_nettype wire

// File: design/sector_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module sector_receiver import cdic_pkg::*; #(
    parameter int sector_words = 1188
) (
    input  wire              clk,
    input  wire              reset,
    input  wire cdic_word_t  cd_data,
    input  wire              cd_data_valid,
    input  wire              cd_sector_tick,
    output ram_addr_t        ram_addr,
    output cdic_word_t       ram_data,
    output logic             ram_we,
    output logic             fail_not_enough_words,
    output logic             fail_too_much_data,
    sector_ctrl_if.receiver  ctrl
);

    localparam int index_width = 12;

    logic [index_width-1:0] word_index;
    ram_addr_t              wr_addr;
    logic                   buf_b;
    logic                   use_sector;
    logic                   header_mode2;
    logic                   file_match;
    logic                   channel_match;
    submode_t               submode;
    logic                   reject;
    logic                   sector_done;
    ram_addr_t              cur_base;
    ram_addr_t              next_base;

    assign cur_base  = buf_b ? buffer_base_b : buffer_base_a;
    assign next_base = buf_b ? buffer_base_a : buffer_base_b;

    // Mode 1 always passes. In Mode 2 the file must match, and only
    // end-of-record, trigger or end-of-file sectors skip the channel check
    assign reject = header_mode2 &&
                    (!file_match ||
                     (!(submode.eof || submode.trig || submode.eor) &&
                      (!(submode.data || submode.audio || submode.video) || !channel_match)));

    assign sector_done = cd_sector_tick && ctrl.reading_active && use_sector &&
                         (word_index != '0);

    assign ram_we   = cd_data_valid && ctrl.reading_active && use_sector &&
                      (word_index >= first_stored_index);
    assign ram_addr = wr_addr;
    assign ram_data = cd_data;

    assign ctrl.sector_stored = sector_done;
    assign ctrl.stored_in_a   = !buf_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            word_index            <= '0;
            wr_addr               <= buffer_base_a + stored_offset;
            buf_b                 <= 1'b0;
            use_sector            <= 1'b0;
            header_mode2          <= 1'b0;
            fail_not_enough_words <= 1'b0;
            fail_too_much_data    <= 1'b0;
        end else if (ctrl.restart) begin
            word_index <= '0;
            wr_addr    <= buffer_base_a + stored_offset;
            buf_b      <= 1'b0;
            use_sector <= 1'b0;
        end else begin
            if (cd_data_valid && ctrl.reading_active) begin
                // Saturate so an overlong sector cannot wrap back to zero
                if (word_index != '1) begin
                    word_index <= word_index + 1'b1;
                end
                if (word_index == hdr_mode_index) begin
                    header_mode2 <= (cd_data[7:0] == 8'd2) && ctrl.read_mode2;
                end
                if (word_index == filter_index && reject) begin
                    use_sector <= 1'b0;
                end
            end

            if (ram_we) begin
                wr_addr <= wr_addr + 1'b1;
            end

            if (cd_sector_tick) begin
                word_index <= '0;
                if (ctrl.reading_active) begin
                    use_sector <= 1'b1;
                    // A filtered sector leaves its buffer free for the next one
                    wr_addr    <= cur_base + stored_offset;
                    if (sector_done) begin
                        if (word_index < sector_words) begin
                            fail_not_enough_words <= 1'b1;
                        end
                        if (word_index > sector_words) begin
                            fail_too_much_data <= 1'b1;
                        end
                        buf_b   <= !buf_b;
                        wr_addr <= next_base + stored_offset;
                    end
                end
            end
        end
    end

    // Header fields, only looked at once the mode word has been seen
    always_ff @(posedge clk) begin
        if (cd_data_valid) begin
            if (word_index == hdr_file_index) begin
                file_match    <= (cd_data[15:8] == ctrl.file_id);
                channel_match <= ctrl.channel_mask[cd_data[4:0]];
            end
            if (word_index == hdr_submode_index) begin
                submode <= cd_data[15:8];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cdic_control.sv
`timescale 1ns/1ps
`default_nettype none

module cdic_control import cdic_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire ram_addr_t   address,
    input  wire cdic_word_t  din,
    input  wire              write_strobe,
    input  wire              cs,
    input  wire              cd_sector_tick,
    output cdic_word_t       dout,
    output logic             bus_ack,
    output logic             intreq,
    output logic [31:0]      cd_seek_lba,
    output logic             cd_seek_lba_valid,
    ram_port_if.master       ram,
    sector_ctrl_if.control   sector
);

    cdic_word_t  cmd_reg;
    time_reg_u   time_reg;
    cdic_word_t  file_reg;
    logic [31:0] chan_reg;
    cdic_word_t  xbuf;
    cdic_word_t  dbuf;
    logic [1:0]  spin_cnt;
    logic        reading_active;
    logic        read_mode2;
    logic        restart;
    logic [31:0] time_lba;
    logic        bus_write;
    logic        bus_read;

    msf_to_lba msf_to_lba_i (
        .msf (time_reg),
        .lba (time_lba)
    );

    // Accesses complete in the single bus_ack cycle
    assign bus_write = cs && write_strobe && bus_ack;
    assign bus_read  = cs && !write_strobe && bus_ack;

    assign ram.addr  = address;
    assign ram.wdata = din;
    assign ram.we    = bus_write && (address < ram_limit_addr);

    assign intreq = xbuf[15] & dbuf[14];

    assign sector.reading_active = reading_active;
    assign sector.read_mode2     = read_mode2;
    assign sector.file_id        = file_reg[15:8];
    assign sector.channel_mask   = chan_reg;
    assign sector.restart        = restart;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack           <= 1'b0;
            cmd_reg           <= '0;
            time_reg          <= '0;
            file_reg          <= '0;
            chan_reg          <= '0;
            xbuf              <= '0;
            dbuf              <= '0;
            spin_cnt          <= '0;
            reading_active    <= 1'b0;
            read_mode2        <= 1'b0;
            restart           <= 1'b0;
            cd_seek_lba       <= '0;
            cd_seek_lba_valid <= 1'b0;
        end else begin
            bus_ack           <= cs && !bus_ack;
            cd_seek_lba_valid <= 1'b0;
            restart           <= 1'b0;

            // CPU still sees bit 15 in this read, it clears afterwards
            if (bus_read && address == reg_xbuf_addr) begin
                xbuf[15] <= 1'b0;
            end

            // Stop reports completion only after the drive has spun down
            if (spin_cnt != 2'd0 && cd_sector_tick) begin
                spin_cnt <= spin_cnt - 2'd1;
                if (spin_cnt == 2'd1) begin
                    xbuf[15] <= 1'b1;
                end
            end

            if (sector.sector_stored) begin
                xbuf[15] <= 1'b1;
                dbuf[0]  <= sector.stored_in_a;
            end

            // Command execution, bit 15 acts as a one shot trigger
            if (dbuf[15]) begin
                dbuf[15] <= 1'b0;
                xbuf[15] <= 1'b0;
                case (cmd_reg)
                    cmd_read_mode1, cmd_seek: begin
                        reading_active    <= 1'b1;
                        read_mode2        <= 1'b0;
                        cd_seek_lba       <= time_lba;
                        cd_seek_lba_valid <= 1'b1;
                    end
                    cmd_read_mode2: begin
                        reading_active    <= 1'b1;
                        read_mode2        <= 1'b1;
                        cd_seek_lba       <= time_lba;
                        cd_seek_lba_valid <= 1'b1;
                    end
                    cmd_stop: begin
                        reading_active <= 1'b0;
                        read_mode2     <= 1'b0;
                        spin_cnt       <= 2'(spin_down_ticks);
                    end
                    default: begin
                    end
                endcase
            end

            if (bus_write) begin
                case (address)
                    reg_cmd_addr:     cmd_reg           <= din;
                    reg_time_hi_addr: time_reg.half[1]  <= din;
                    reg_time_lo_addr: time_reg.half[0]  <= din;
                    reg_file_addr:    file_reg          <= din;
                    reg_chan_hi_addr: chan_reg[31:16]   <= din;
                    reg_chan_lo_addr: chan_reg[15:0]    <= din;
                    reg_xbuf_addr:    xbuf              <= din;
                    reg_dbuf_addr: begin
                        dbuf <= din;
                        // Clearing bit 14 halts reading and rewinds to buffer A
                        if (!din[14]) begin
                            reading_active <= 1'b0;
                            restart        <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (address)
            reg_cmd_addr:     dout = cmd_reg;
            reg_time_hi_addr: dout = time_reg.half[1];
            reg_time_lo_addr: dout = time_reg.half[0];
            reg_file_addr:    dout = file_reg;
            reg_chan_hi_addr: dout = chan_reg[31:16];
            reg_chan_lo_addr: dout = chan_reg[15:0];
            reg_xbuf_addr:    dout = xbuf;
            reg_dbuf_addr:    dout = dbuf;
            default:          dout = (address < ram_limit_addr) ? ram.rdata : '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/cdic_top.sv
`timescale 1ns/1ps
`default_nettype none

module cdic_top import cdic_pkg::*; #(
    parameter int sector_words = 1188
) (
    input  wire              clk,
    input  wire              reset,

    // CPU bus
    input  wire ram_addr_t   address,
    input  wire cdic_word_t  din,
    input  wire              write_strobe,
    input  wire              cs,
    output cdic_word_t       dout,
    output logic             bus_ack,
    output logic             intreq,

    // CD source
    input  wire cdic_word_t  cd_data,
    input  wire              cd_data_valid,
    input  wire              cd_sector_tick,
    output logic [31:0]      cd_seek_lba,
    output logic             cd_seek_lba_valid,

    // Sticky sector length flags
    output logic             fail_not_enough_words,
    output logic             fail_too_much_data
);

    ram_port_if    ram_bus ();
    sector_ctrl_if sector_bus ();

    ram_addr_t  port_b_addr;
    cdic_word_t port_b_data;
    logic       port_b_we;

    cdic_control cdic_control_i (
        .clk               (clk),
        .reset             (reset),
        .address           (address),
        .din               (din),
        .write_strobe      (write_strobe),
        .cs                (cs),
        .cd_sector_tick    (cd_sector_tick),
        .dout              (dout),
        .bus_ack           (bus_ack),
        .intreq            (intreq),
        .cd_seek_lba       (cd_seek_lba),
        .cd_seek_lba_valid (cd_seek_lba_valid),
        .ram               (ram_bus.master),
        .sector            (sector_bus.control)
    );

    sector_receiver #(
        .sector_words (sector_words)
    ) sector_receiver_i (
        .clk                   (clk),
        .reset                 (reset),
        .cd_data               (cd_data),
        .cd_data_valid         (cd_data_valid),
        .cd_sector_tick        (cd_sector_tick),
        .ram_addr              (port_b_addr),
        .ram_data              (port_b_data),
        .ram_we                (port_b_we),
        .fail_not_enough_words (fail_not_enough_words),
        .fail_too_much_data    (fail_too_much_data),
        .ctrl                  (sector_bus.receiver)
    );

    sector_ram sector_ram_i (
        .clk         (clk),
        .port_b_addr (port_b_addr),
        .port_b_data (port_b_data),
        .port_b_we   (port_b_we),
        .cpu         (ram_bus.slave)
    );

endmodule

`default_nettype wire

// File: test/cdic_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cdic_assertions (
    input wire clk,
    input wire reset,
    input wire bus_ack,
    input wire cd_seek_lba_valid,
    input wire intreq,
    input wire interrupt_enable
);

    int failure_count = 0;

    bus_ack_single: assert property (@(posedge clk) disable iff (reset) bus_ack |=> !bus_ack)
        else begin
            failure_count++;
            $error("bus_ack stayed high for two cycles");
        end

    seek_pulse_single: assert property (@(posedge clk) disable iff (reset)
            cd_seek_lba_valid |=> !cd_seek_lba_valid)
        else begin
            failure_count++;
            $error("cd_seek_lba_valid was longer than one cycle");
        end

    // Interrupt only while DBUF bit 14 enables it
    intreq_enabled: assert property (@(posedge clk) disable iff (reset)
            !interrupt_enable |-> !intreq)
        else begin
            failure_count++;
            $error("intreq high while DBUF bit 14 is clear");
        end

endmodule

bind cdic_top cdic_assertions cdic_assertions_i (
    .clk               (clk),
    .reset             (reset),
    .bus_ack           (bus_ack),
    .cd_seek_lba_valid (cd_seek_lba_valid),
    .intreq            (intreq),
    .interrupt_enable  (cdic_control_i.dbuf[14])
);

`default_nettype wire

// File: test/cdic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cdic_tb import cdic_pkg::*; ();

    localparam int sector_len = 64;
    // Rough cycle cost of each test with margin on every bus access
    localparam int access_budget  = 14 * 4;
    localparam int seek_budget    = 12 * 4 + 8;
    localparam int storage_budget = 2 * (sector_len + 4) + 130 * 4;
    localparam int filter_budget  = 3 * (sector_len + 10) + 8 * 4;
    localparam int length_budget  = 2 * (sector_len + 10) + 6 * 4;
    localparam int stop_budget    = 3 * 6 + 4 * 4;
    localparam int cycle_limit    = 2 * (16 + access_budget + seek_budget + storage_budget +
                                         filter_budget + length_budget + stop_budget);

    logic        clk = 1'b0;
    logic        reset;
    ram_addr_t   address;
    cdic_word_t  din;
    logic        write_strobe;
    logic        cs;
    cdic_word_t  cd_data;
    logic        cd_data_valid;
    logic        cd_sector_tick;
    cdic_word_t  dout;
    logic        bus_ack;
    logic        intreq;
    logic [31:0] cd_seek_lba;
    logic        cd_seek_lba_valid;
    logic        fail_not_enough_words;
    logic        fail_too_much_data;

    logic [31:0] lfsr_state = 32'h335915aa;
    cdic_word_t  sector_buf [0:sector_len-1];
    string       test_name = "";
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          test_errors = 0;
    int          cycle_count = 0;
    int          seek_pulses = 0;
    logic [31:0] seek_lba_seen = '0;

    cdic_top #(
        .sector_words (sector_len)
    ) cdic_top_i (
        .clk                   (clk),
        .reset                 (reset),
        .address               (address),
        .din                   (din),
        .write_strobe          (write_strobe),
        .cs                    (cs),
        .dout                  (dout),
        .bus_ack               (bus_ack),
        .intreq                (intreq),
        .cd_data               (cd_data),
        .cd_data_valid         (cd_data_valid),
        .cd_sector_tick        (cd_sector_tick),
        .cd_seek_lba           (cd_seek_lba),
        .cd_seek_lba_valid     (cd_seek_lba_valid),
        .fail_not_enough_words (fail_not_enough_words),
        .fail_too_much_data    (fail_too_much_data)
    );

    always #50 clk = ~clk;

    // Counts every cycle with the seek strobe high
    always @(negedge clk) begin
        if (cd_seek_lba_valid) begin
            seek_pulses = seek_pulses + 1;
            seek_lba_seen = cd_seek_lba;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic random_word(output cdic_word_t word);
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word[i] = lfsr_state[0];
        end
    endtask

    task automatic check_word(input string name, input cdic_word_t expected,
                              input cdic_word_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s, %s: expected %h, actual %h",
                     test_name, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_lba(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s, %s: expected %0d, actual %0d",
                     test_name, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s, %s: expected %b, actual %b",
                     test_name, name, expected, actual);
            test_errors++;
        end
    endtask

    // Starts on a falling edge and returns on the one after the idle cycle
    task automatic bus_access(input ram_addr_t addr, input cdic_word_t wdata,
                              input logic write, output cdic_word_t rdata);
        int wait_cycles;
        wait_cycles = 0;
        address = addr;
        din = wdata;
        write_strobe = write;
        cs = 1'b1;
        @(negedge clk);
        while (!bus_ack && wait_cycles < 8) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!bus_ack) begin
            $display("Bus access to address %h got no bus_ack", addr);
            test_errors++;
        end
        rdata = dout;
        @(negedge clk);
        cs = 1'b0;
        write_strobe = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input ram_addr_t addr, input cdic_word_t data);
        cdic_word_t unused;
        bus_access(addr, data, 1'b1, unused);
    endtask

    task automatic bus_read(input ram_addr_t addr, output cdic_word_t data);
        bus_access(addr, 16'h0000, 1'b0, data);
    endtask

    task automatic sector_tick();
        cd_sector_tick = 1'b1;
        @(negedge clk);
        cd_sector_tick = 1'b0;
    endtask

    task automatic build_sector(input logic [7:0] mode, input logic [7:0] file,
                                input logic [4:0] channel, input submode_t submode);
        for (int i = 0; i < sector_len; i++) begin
            random_word(sector_buf[i]);
        end
        sector_buf[7] = {8'h00, mode};
        sector_buf[8] = {file, 3'b000, channel};
        sector_buf[9] = {submode, 8'h00};
    endtask

    // Opening tick, the words, then the closing tick
    task automatic send_sector(input int words);
        sector_tick();
        for (int i = 0; i < words; i++) begin
            cd_data = sector_buf[i];
            cd_data_valid = 1'b1;
            @(negedge clk);
        end
        cd_data_valid = 1'b0;
        sector_tick();
    endtask

    task automatic wait_intreq(output logic seen);
        seen = intreq;
        for (int i = 0; i < 6 && !seen; i++) begin
            @(negedge clk);
            seen = intreq;
        end
    endtask

    // Stop and rewind to buffer A, then trigger with interrupts enabled
    task automatic run_command(input cdic_word_t cmd);
        bus_write(reg_dbuf_addr, 16'h0000);
        bus_write(reg_cmd_addr, cmd);
        bus_write(reg_dbuf_addr, 16'hC000);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        test_count++;
        error_count += test_errors;
        $display("Test %s finished with %0d errors", test_name, test_errors);
        test_errors = 0;
    endtask

    task automatic test_register_access();
        cdic_word_t value;
        start_test("register_access");
        bus_write(reg_file_addr, 16'h4100);
        bus_write(reg_chan_hi_addr, 16'hA5C3);
        bus_write(reg_chan_lo_addr, 16'h0008);
        bus_write(reg_time_hi_addr, 16'h1234);
        bus_write(reg_time_lo_addr, 16'h5600);
        bus_write(13'h0123, 16'hBEEF);
        bus_write(13'h1DFF, 16'h5A5A);
        bus_read(reg_file_addr, value);
        check_word("file register", 16'h4100, value);
        bus_read(reg_chan_hi_addr, value);
        check_word("channel high", 16'hA5C3, value);
        bus_read(reg_chan_lo_addr, value);
        check_word("channel low", 16'h0008, value);
        bus_read(reg_time_hi_addr, value);
        check_word("time high", 16'h1234, value);
        bus_read(reg_time_lo_addr, value);
        check_word("time low", 16'h5600, value);
        bus_read(13'h0123, value);
        check_word("memory word 0x0123", 16'hBEEF, value);
        bus_read(13'h1DFF, value);
        check_word("memory word 0x1DFF", 16'h5A5A, value);
        finish_test();
    endtask

    task automatic test_seek_address();
        cdic_word_t value;
        start_test("seek_address");
        bus_write(reg_time_hi_addr, 16'h0002);
        bus_write(reg_time_lo_addr, 16'h1600);
        seek_pulses = 0;
        run_command(cmd_read_mode1);
        repeat (4) @(negedge clk);
        check_bit("single seek pulse", 1'b1, seek_pulses == 1);
        check_lba("seek 00:02:16", (0 * 60 + 2) * 75 + 16, seek_lba_seen);
        bus_read(reg_dbuf_addr, value);
        check_bit("dbuf trigger cleared", 1'b0, value[15]);
        // Frame tens digit 9 has its top bit set
        bus_write(reg_time_lo_addr, 16'h9600);
        seek_pulses = 0;
        run_command(cmd_seek);
        repeat (4) @(negedge clk);
        check_bit("single seek pulse", 1'b1, seek_pulses == 1);
        check_lba("seek with frames dropped", (0 * 60 + 2) * 75, seek_lba_seen);
        finish_test();
    endtask

    task automatic test_mode1_storage();
        cdic_word_t value;
        logic       seen;
        start_test("mode1_storage");
        run_command(cmd_read_mode1);
        build_sector(8'd1, 8'h00, 5'd0, '0);
        send_sector(sector_len);
        wait_intreq(seen);
        check_bit("intreq after first sector", 1'b1, seen);
        bus_read(reg_dbuf_addr, value);
        check_bit("first sector in buffer A", 1'b1, value[0]);
        for (int i = 8; i < sector_len; i++) begin
            bus_read(13'h0502 + ram_addr_t'(i - 8), value);
            check_word($sformatf("buffer A word %0d", i), sector_buf[i], value);
        end
        bus_read(reg_xbuf_addr, value);
        check_bit("xbuf sector flag", 1'b1, value[15]);
        check_bit("intreq cleared by xbuf read", 1'b0, intreq);
        build_sector(8'd1, 8'h00, 5'd0, '0);
        send_sector(sector_len);
        wait_intreq(seen);
        check_bit("intreq after second sector", 1'b1, seen);
        for (int i = 8; i < sector_len; i++) begin
            bus_read(13'h0002 + ram_addr_t'(i - 8), value);
            check_word($sformatf("buffer B word %0d", i), sector_buf[i], value);
        end
        bus_read(reg_dbuf_addr, value);
        check_bit("second sector in buffer B", 1'b0, value[0]);
        bus_read(reg_xbuf_addr, value);
        finish_test();
    endtask

    task automatic test_mode2_filter();
        cdic_word_t value;
        logic       seen;
        submode_t   data_only;
        start_test("mode2_filter");
        data_only = '0;
        data_only.data = 1'b1;
        // File 0x41 with only channel 3 enabled
        bus_write(reg_file_addr, 16'h4100);
        bus_write(reg_chan_hi_addr, 16'h0000);
        bus_write(reg_chan_lo_addr, 16'h0008);
        run_command(cmd_read_mode2);
        build_sector(8'd2, 8'h42, 5'd3, data_only);
        send_sector(sector_len);
        wait_intreq(seen);
        check_bit("wrong file filtered", 1'b0, seen);
        build_sector(8'd2, 8'h41, 5'd5, data_only);
        send_sector(sector_len);
        wait_intreq(seen);
        check_bit("masked channel filtered", 1'b0, seen);
        build_sector(8'd2, 8'h41, 5'd3, data_only);
        send_sector(sector_len);
        wait_intreq(seen);
        check_bit("matching sector stored", 1'b1, seen);
        bus_read(reg_dbuf_addr, value);
        check_bit("rejected buffer reused", 1'b1, value[0]);
        bus_read(reg_xbuf_addr, value);
        finish_test();
    endtask

    task automatic test_length_check();
        cdic_word_t value;
        logic       seen;
        start_test("length_check");
        check_bit("short flag before", 1'b0, fail_not_enough_words);
        run_command(cmd_read_mode1);
        build_sector(8'd1, 8'h00, 5'd0, '0);
        send_sector(40);
        wait_intreq(seen);
        check_bit("short sector stored", 1'b1, seen);
        check_bit("short flag set", 1'b1, fail_not_enough_words);
        check_bit("long flag clear", 1'b0, fail_too_much_data);
        bus_read(reg_xbuf_addr, value);
        send_sector(sector_len);
        wait_intreq(seen);
        check_bit("full sector stored", 1'b1, seen);
        check_bit("short flag sticky", 1'b1, fail_not_enough_words);
        bus_read(reg_xbuf_addr, value);
        finish_test();
    endtask

    task automatic test_stop();
        logic seen;
        start_test("stop");
        run_command(cmd_stop);
        for (int tick = 1; tick < 3; tick++) begin
            sector_tick();
            repeat (3) @(negedge clk);
            check_bit($sformatf("no intreq after tick %0d", tick), 1'b0, intreq);
        end
        sector_tick();
        wait_intreq(seen);
        check_bit("intreq after third tick", 1'b1, seen);
        finish_test();
    endtask

    initial begin
        reset = 1'b1;
        address = '0;
        din = '0;
        write_strobe = 1'b0;
        cs = 1'b0;
        cd_data = '0;
        cd_data_valid = 1'b0;
        cd_sector_tick = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_register_access();
        test_seek_address();
        test_mode1_storage();
        test_mode2_filter();
        test_length_check();
        test_stop();

        error_count += cdic_top_i.cdic_assertions_i.failure_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, error_count,
                 cdic_top_i.cdic_assertions_i.failure_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/cdic_pkg.sv
design/cdic_ifs.sv
design/msf_to_lba.sv
design/sector_ram.sv
design/sector_receiver.sv
design/cdic_control.sv
design/cdic_top.sv
test/cdic_assertions.sv
test/cdic_tb.sv

// File: Bender.yml
package:
  name: cdic

sources:
  - design/cdic_pkg.sv
  - design/cdic_ifs.sv
  - design/msf_to_lba.sv
  - design/sector_ram.sv
  - design/sector_receiver.sv
  - design/cdic_control.sv
  - design/cdic_top.sv
  - target: test
    files:
      - test/cdic_assertions.sv
      - test/cdic_tb.sv
